/* hdl/warp_decode_pkg.sv */
package warp_decode_pkg;

    // Word and field types
    typedef logic [31:0] instruction_t;
    typedef logic [31:0] data_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  funct4_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [2:0]  opcode_t;

    // Major opcodes, bits 31:29
    localparam opcode_t OPCODE_R      = 3'b000;
    localparam opcode_t OPCODE_I      = 3'b001;
    localparam opcode_t OPCODE_M      = 3'b011;
    localparam opcode_t OPCODE_UP     = 3'b100;
    localparam opcode_t OPCODE_SX_SLT = 3'b101;
    localparam opcode_t OPCODE_J      = 3'b111;

    // Field positions inside the instruction word
    localparam int OPCODE_MSB = 31;
    localparam int RD_LSB     = 0;
    localparam int RS1_LSB    = 5;
    localparam int FUNCT_LSB  = 10;
    localparam int RS2_LSB    = 14;

    // Where each format keeps its scalar flag
    localparam int SCALAR_BIT_ALU = 28;
    localparam int SCALAR_BIT_MEM = 13;
    localparam int SCALAR_BIT_UP  = 5;

    // funct3 sub-codes under OPCODE_J
    localparam funct3_t FUNCT3_JAL  = 3'b000;
    localparam funct3_t FUNCT3_BEQZ = 3'b001;
    localparam funct3_t FUNCT3_BEQO = 3'b010;
    localparam funct3_t FUNCT3_HALT = 3'b111;

    // funct3 sub-codes under OPCODE_M
    localparam funct3_t FUNCT3_LW = 3'b000;
    localparam funct3_t FUNCT3_SW = 3'b001;

    typedef enum logic [3:0] {
        FMT_NONE,
        FMT_R,
        FMT_I,
        FMT_LOAD,
        FMT_STORE,
        FMT_BRANCH_Z,
        FMT_BRANCH_O,
        FMT_JUMP,
        FMT_UPPER,
        FMT_SX,
        FMT_HALT
    } instr_format_t;

    // 19 operations, so five bits
    typedef enum logic [4:0] {
        ALU_NOP,
        ADD,
        SUB,
        MUL,
        DIV,
        SLT,
        SLL,
        SEQ,
        SNEZ,
        MIN,
        ABS,
        ADDI,
        MULI,
        DIVI,
        SLLI,
        SEQI,
        JAL,
        BEQZ,
        BEQO
    } alu_op_t;

    typedef enum logic [1:0] {
        ALU_OUT,
        LSU_OUT,
        IMMEDIATE,
        VECTOR_TO_SCALAR
    } reg_input_mux_t;

endpackage

/* hdl/format_decode.sv */
module format_decode (
    input  warp_decode_pkg::instruction_t   instruction,
    output warp_decode_pkg::instr_format_t  fmt,
    output logic                            reg_write_enable,
    output logic                            mem_read_enable,
    output logic                            mem_write_enable,
    output logic                            branch,
    output logic                            halt,
    output logic                            scalar,
    output logic                            illegal_format,
    output warp_decode_pkg::reg_input_mux_t reg_input_mux,
    output warp_decode_pkg::reg_addr_t      rd,
    output warp_decode_pkg::reg_addr_t      rs1,
    output warp_decode_pkg::reg_addr_t      rs2
);

    warp_decode_pkg::opcode_t   opcode;
    warp_decode_pkg::funct3_t   funct3;
    warp_decode_pkg::reg_addr_t rd_field;
    warp_decode_pkg::reg_addr_t rs1_field;
    warp_decode_pkg::reg_addr_t rs2_field;

    assign opcode    = instruction[warp_decode_pkg::OPCODE_MSB -: 3];
    assign funct3    = instruction[warp_decode_pkg::FUNCT_LSB +: 3];
    assign rd_field  = instruction[warp_decode_pkg::RD_LSB +: 5];
    assign rs1_field = instruction[warp_decode_pkg::RS1_LSB +: 5];
    assign rs2_field = instruction[warp_decode_pkg::RS2_LSB +: 5];

    // Opcode and funct3 to format
    always_comb begin
        fmt = warp_decode_pkg::FMT_NONE;
        case (opcode)
            warp_decode_pkg::OPCODE_R:      fmt = warp_decode_pkg::FMT_R;
            warp_decode_pkg::OPCODE_I:      fmt = warp_decode_pkg::FMT_I;
            warp_decode_pkg::OPCODE_UP:     fmt = warp_decode_pkg::FMT_UPPER;
            warp_decode_pkg::OPCODE_SX_SLT: fmt = warp_decode_pkg::FMT_SX;
            warp_decode_pkg::OPCODE_M: begin
                case (funct3)
                    warp_decode_pkg::FUNCT3_LW: fmt = warp_decode_pkg::FMT_LOAD;
                    warp_decode_pkg::FUNCT3_SW: fmt = warp_decode_pkg::FMT_STORE;
                    default:                    fmt = warp_decode_pkg::FMT_NONE;
                endcase
            end
            warp_decode_pkg::OPCODE_J: begin
                case (funct3)
                    warp_decode_pkg::FUNCT3_JAL:  fmt = warp_decode_pkg::FMT_JUMP;
                    warp_decode_pkg::FUNCT3_BEQZ: fmt = warp_decode_pkg::FMT_BRANCH_Z;
                    warp_decode_pkg::FUNCT3_BEQO: fmt = warp_decode_pkg::FMT_BRANCH_O;
                    warp_decode_pkg::FUNCT3_HALT: fmt = warp_decode_pkg::FMT_HALT;
                    default:                      fmt = warp_decode_pkg::FMT_NONE;
                endcase
            end
            // 010 was the float opcode, now unrecognized
            default: fmt = warp_decode_pkg::FMT_NONE;
        endcase
    end

    // Control fields per format
    always_comb begin
        reg_write_enable = 1'b0;
        mem_read_enable  = 1'b0;
        mem_write_enable = 1'b0;
        branch           = 1'b0;
        halt             = 1'b0;
        scalar           = 1'b0;
        illegal_format   = 1'b0;
        reg_input_mux    = warp_decode_pkg::ALU_OUT;
        rd               = '0;
        rs1              = '0;
        rs2              = '0;
        case (fmt)
            warp_decode_pkg::FMT_R: begin
                rd               = rd_field;
                rs1              = rs1_field;
                rs2              = rs2_field;
                reg_write_enable = 1'b1;
                scalar           = instruction[warp_decode_pkg::SCALAR_BIT_ALU];
            end
            warp_decode_pkg::FMT_I: begin
                rd               = rd_field;
                rs1              = rs1_field;
                reg_write_enable = 1'b1;
                scalar           = instruction[warp_decode_pkg::SCALAR_BIT_ALU];
            end
            warp_decode_pkg::FMT_LOAD: begin
                rd               = rd_field;
                rs1              = rs1_field;
                reg_write_enable = 1'b1;
                mem_read_enable  = 1'b1;
                reg_input_mux    = warp_decode_pkg::LSU_OUT;
                scalar           = instruction[warp_decode_pkg::SCALAR_BIT_MEM];
            end
            warp_decode_pkg::FMT_STORE: begin
                rs1              = rs1_field;
                rs2              = rs2_field;
                mem_write_enable = 1'b1;
                scalar           = instruction[warp_decode_pkg::SCALAR_BIT_MEM];
            end
            warp_decode_pkg::FMT_BRANCH_Z, warp_decode_pkg::FMT_BRANCH_O: begin
                rs1    = rs1_field;
                rs2    = rs2_field;
                branch = 1'b1;
                scalar = 1'b1;
            end
            warp_decode_pkg::FMT_JUMP: scalar = 1'b1;
            warp_decode_pkg::FMT_HALT: begin
                halt   = 1'b1;
                scalar = 1'b1;
            end
            warp_decode_pkg::FMT_UPPER: begin
                rd               = rd_field;
                reg_write_enable = 1'b1;
                reg_input_mux    = warp_decode_pkg::IMMEDIATE;
                scalar           = instruction[warp_decode_pkg::SCALAR_BIT_UP];
            end
            warp_decode_pkg::FMT_SX: begin
                rd               = rd_field;
                rs1              = rs1_field;
                rs2              = rs2_field;
                reg_write_enable = 1'b1;
                reg_input_mux    = warp_decode_pkg::VECTOR_TO_SCALAR;
            end
            default: illegal_format = 1'b1;
        endcase
    end

    always_comb begin
        a_fmt_known: assert final (!$isunknown(fmt))
            else $error("format_decode: unknown format for instruction %h", instruction);
    end

endmodule

/* hdl/alu_op_decode.sv */
module alu_op_decode (
    input  warp_decode_pkg::instr_format_t fmt,
    input  warp_decode_pkg::funct4_t       funct4,
    output warp_decode_pkg::alu_op_t       alu_op,
    output logic                           illegal_funct
);

    always_comb begin
        alu_op        = warp_decode_pkg::ALU_NOP;
        illegal_funct = 1'b0;
        case (fmt)
            warp_decode_pkg::FMT_R: begin
                case (funct4)
                    4'd0:    alu_op = warp_decode_pkg::ADD;
                    4'd1:    alu_op = warp_decode_pkg::SUB;
                    4'd2:    alu_op = warp_decode_pkg::MUL;
                    4'd3:    alu_op = warp_decode_pkg::DIV;
                    4'd4:    alu_op = warp_decode_pkg::SLT;
                    4'd5:    alu_op = warp_decode_pkg::SLL;
                    4'd6:    alu_op = warp_decode_pkg::SEQ;
                    4'd7:    alu_op = warp_decode_pkg::SNEZ;
                    4'd8:    alu_op = warp_decode_pkg::MIN;
                    4'd9:    alu_op = warp_decode_pkg::ABS;
                    default: illegal_funct = 1'b1;
                endcase
            end
            warp_decode_pkg::FMT_I: begin
                case (funct4)
                    4'd0:    alu_op = warp_decode_pkg::ADDI;
                    4'd2:    alu_op = warp_decode_pkg::MULI;
                    4'd3:    alu_op = warp_decode_pkg::DIVI;
                    4'd10:   alu_op = warp_decode_pkg::SLLI;
                    4'd11:   alu_op = warp_decode_pkg::SEQI;
                    default: illegal_funct = 1'b1;
                endcase
            end
            warp_decode_pkg::FMT_SX: begin
                if (funct4 == 4'd0) begin
                    alu_op = warp_decode_pkg::SLT;
                end else begin
                    illegal_funct = 1'b1;
                end
            end
            // Effective address is base plus offset
            warp_decode_pkg::FMT_LOAD, warp_decode_pkg::FMT_STORE: begin
                alu_op = warp_decode_pkg::ADDI;
            end
            warp_decode_pkg::FMT_JUMP:     alu_op = warp_decode_pkg::JAL;
            warp_decode_pkg::FMT_BRANCH_Z: alu_op = warp_decode_pkg::BEQZ;
            warp_decode_pkg::FMT_BRANCH_O: alu_op = warp_decode_pkg::BEQO;
            default:                       alu_op = warp_decode_pkg::ALU_NOP;
        endcase
    end

endmodule

/* hdl/imm_gen.sv */
module imm_gen (
    input  warp_decode_pkg::instr_format_t fmt,
    input  warp_decode_pkg::instruction_t  instruction,
    output warp_decode_pkg::data_t         immediate
);

    logic [13:0] imm_i;
    logic [14:0] imm_load;
    logic [14:0] imm_s;
    logic [15:0] imm_b;
    logic [25:0] imm_j;
    logic [19:0] imm_u;

    // Gather the scattered immediate bits
    assign imm_i    = instruction[27:14];
    assign imm_load = instruction[28:14];
    assign imm_s    = {instruction[28:19], instruction[4:0]};
    assign imm_b    = {instruction[28:19], instruction[13], instruction[4:0]};
    assign imm_j    = {instruction[28:13], instruction[9:0]};
    assign imm_u    = instruction[28:9];

    always_comb begin
        case (fmt)
            warp_decode_pkg::FMT_I: begin
                immediate = {{18{imm_i[13]}}, imm_i};
            end
            warp_decode_pkg::FMT_LOAD: begin
                immediate = {{17{imm_load[14]}}, imm_load};
            end
            warp_decode_pkg::FMT_STORE: begin
                immediate = {{17{imm_s[14]}}, imm_s};
            end
            warp_decode_pkg::FMT_BRANCH_Z, warp_decode_pkg::FMT_BRANCH_O: begin
                immediate = {{16{imm_b[15]}}, imm_b};
            end
            warp_decode_pkg::FMT_JUMP: begin
                immediate = {{6{imm_j[25]}}, imm_j};
            end
            // LUI fills the upper 20 bits
            warp_decode_pkg::FMT_UPPER: begin
                immediate = {imm_u, 12'b0};
            end
            default: begin
                immediate = '0;
            end
        endcase
    end

endmodule

/* hdl/warp_decoder.sv */
module warp_decoder (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            decode_valid,
    input  warp_decode_pkg::instruction_t   instruction,
    output logic                            decoded_valid,
    output logic                            decoded_reg_write_enable,
    output logic                            decoded_mem_write_enable,
    output logic                            decoded_mem_read_enable,
    output logic                            decoded_branch,
    output logic                            decoded_scalar_instruction,
    output logic                            decoded_halt,
    output logic                            decoded_illegal,
    output warp_decode_pkg::reg_input_mux_t decoded_reg_input_mux,
    output warp_decode_pkg::data_t          decoded_immediate,
    output warp_decode_pkg::reg_addr_t      decoded_rd_address,
    output warp_decode_pkg::reg_addr_t      decoded_rs1_address,
    output warp_decode_pkg::reg_addr_t      decoded_rs2_address,
    output warp_decode_pkg::alu_op_t        decoded_alu_instruction
);

    warp_decode_pkg::instr_format_t  fmt;
    warp_decode_pkg::funct4_t        funct4;
    warp_decode_pkg::reg_input_mux_t reg_input_mux;
    warp_decode_pkg::reg_addr_t      rd;
    warp_decode_pkg::reg_addr_t      rs1;
    warp_decode_pkg::reg_addr_t      rs2;
    warp_decode_pkg::alu_op_t        alu_op;
    warp_decode_pkg::data_t          immediate;
    logic reg_write_enable;
    logic mem_read_enable;
    logic mem_write_enable;
    logic branch;
    logic halt;
    logic scalar;
    logic illegal_format;
    logic illegal_funct;

    assign funct4 = instruction[warp_decode_pkg::FUNCT_LSB +: 4];

    format_decode u_format_decode (
        .instruction      (instruction),
        .fmt              (fmt),
        .reg_write_enable (reg_write_enable),
        .mem_read_enable  (mem_read_enable),
        .mem_write_enable (mem_write_enable),
        .branch           (branch),
        .halt             (halt),
        .scalar           (scalar),
        .illegal_format   (illegal_format),
        .reg_input_mux    (reg_input_mux),
        .rd               (rd),
        .rs1              (rs1),
        .rs2              (rs2)
    );

    alu_op_decode u_alu_op_decode (
        .fmt           (fmt),
        .funct4        (funct4),
        .alu_op        (alu_op),
        .illegal_funct (illegal_funct)
    );

    imm_gen u_imm_gen (
        .fmt         (fmt),
        .instruction (instruction),
        .immediate   (immediate)
    );

    // Bundle is captured on the strobe and held until the next one
    always_ff @(posedge clk) begin
        if (reset) begin
            decoded_valid              <= 1'b0;
            decoded_reg_write_enable   <= 1'b0;
            decoded_mem_write_enable   <= 1'b0;
            decoded_mem_read_enable    <= 1'b0;
            decoded_branch             <= 1'b0;
            decoded_scalar_instruction <= 1'b0;
            decoded_halt               <= 1'b0;
            decoded_illegal            <= 1'b0;
            decoded_reg_input_mux      <= warp_decode_pkg::ALU_OUT;
            decoded_immediate          <= '0;
            decoded_rd_address         <= '0;
            decoded_rs1_address        <= '0;
            decoded_rs2_address        <= '0;
            decoded_alu_instruction    <= warp_decode_pkg::ALU_NOP;
        end else begin
            decoded_valid <= decode_valid;
            if (decode_valid) begin
                decoded_reg_write_enable   <= reg_write_enable;
                decoded_mem_write_enable   <= mem_write_enable;
                decoded_mem_read_enable    <= mem_read_enable;
                decoded_branch             <= branch;
                decoded_scalar_instruction <= scalar;
                decoded_halt               <= halt;
                decoded_illegal            <= illegal_format | illegal_funct;
                decoded_reg_input_mux      <= reg_input_mux;
                decoded_immediate          <= immediate;
                decoded_rd_address         <= rd;
                decoded_rs1_address        <= rs1;
                decoded_rs2_address        <= rs2;
                decoded_alu_instruction    <= alu_op;
            end
        end
    end

    a_mem_rw_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(decoded_mem_read_enable && decoded_mem_write_enable));

    a_halt_no_write: assert property (@(posedge clk) disable iff (reset)
        decoded_halt |-> !decoded_reg_write_enable);

    a_no_valid_after_reset: assert property (@(posedge clk) reset |=> !decoded_valid);

endmodule

/* verification/decode_checker.sv */
module decode_checker (
    input logic                            clk,
    input logic                            reset,
    input logic                            decode_valid,
    input logic                            decoded_valid,
    input logic                            decoded_reg_write_enable,
    input logic                            decoded_mem_write_enable,
    input logic                            decoded_mem_read_enable,
    input logic                            decoded_branch,
    input logic                            decoded_scalar_instruction,
    input logic                            decoded_halt,
    input logic                            decoded_illegal,
    input warp_decode_pkg::reg_input_mux_t decoded_reg_input_mux,
    input warp_decode_pkg::data_t          decoded_immediate,
    input warp_decode_pkg::reg_addr_t      decoded_rd_address,
    input warp_decode_pkg::reg_addr_t      decoded_rs1_address,
    input warp_decode_pkg::reg_addr_t      decoded_rs2_address,
    input warp_decode_pkg::alu_op_t        decoded_alu_instruction
);
    timeunit 1ns;
    timeprecision 1ns;

    logic [60:0] expected_q[$];
    logic [60:0] actual;
    logic [60:0] exp_bundle;
    logic [60:0] held;
    logic        last_strobe;
    int          value_errors;
    int          protocol_errors;

    function automatic void push_expected(input logic [60:0] bundle);
        expected_q.push_back(bundle);
    endfunction

    function automatic int error_count();
        return value_errors + protocol_errors;
    endfunction

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        if (got !== want) begin
            $display("FAIL t=%0t: field %s got %h expected %h", $time, name, got, want);
            value_errors++;
        end
    endtask

    task automatic compare_bundle(input logic [60:0] got, input logic [60:0] want);
        compare_field("reg_write_enable", got[60], want[60]);
        compare_field("mem_write_enable", got[59], want[59]);
        compare_field("mem_read_enable", got[58], want[58]);
        compare_field("branch", got[57], want[57]);
        compare_field("scalar_instruction", got[56], want[56]);
        compare_field("halt", got[55], want[55]);
        compare_field("illegal", got[54], want[54]);
        compare_field("reg_input_mux", got[53:52], want[53:52]);
        compare_field("immediate", got[51:20], want[51:20]);
        compare_field("rd_address", got[19:15], want[19:15]);
        compare_field("rs1_address", got[14:10], want[14:10]);
        compare_field("rs2_address", got[9:5], want[9:5]);
        compare_field("alu_instruction", got[4:0], want[4:0]);
    endtask

    assign actual = {decoded_reg_write_enable, decoded_mem_write_enable,
                     decoded_mem_read_enable, decoded_branch, decoded_scalar_instruction,
                     decoded_halt, decoded_illegal, decoded_reg_input_mux, decoded_immediate,
                     decoded_rd_address, decoded_rs1_address, decoded_rs2_address,
                     decoded_alu_instruction};

    initial begin
        value_errors = 0;
        protocol_errors = 0;
    end

    // Outputs are stable by the falling edge
    always @(negedge clk) begin
        if (reset) begin
            last_strobe = 1'b0;
            held = '0;
        end else begin
            if (decoded_valid !== last_strobe) begin
                $display("FAIL t=%0t: decoded_valid is %b but strobe a cycle ago was %b",
                         $time, decoded_valid, last_strobe);
                value_errors++;
            end
            if (decoded_valid === 1'b1) begin
                if (expected_q.size() == 0) begin
                    $display("Error at %0t: decoded_valid arrived with no instruction pending",
                             $time);
                    protocol_errors++;
                end else begin
                    exp_bundle = expected_q.pop_front();
                    compare_bundle(actual, exp_bundle);
                    held = exp_bundle;
                end
            end else begin
                // Reset values first, then the last result held between strobes
                compare_bundle(actual, held);
            end
            last_strobe = decode_valid;
        end
    end

    task automatic final_report();
        if (expected_q.size() != 0) begin
            $display("Error: %0d instructions never produced a decoded result",
                     expected_q.size());
            protocol_errors += expected_q.size();
        end
        $display("Errors: %0d value mismatches, %0d protocol errors",
                 value_errors, protocol_errors);
    endtask

endmodule

/* verification/warp_decoder_tb.sv */
module warp_decoder_tb;
    timeunit 1ns;
    timeprecision 1ns;

    logic                            clk;
    logic                            reset;
    logic                            decode_valid;
    warp_decode_pkg::instruction_t   instruction;
    logic                            decoded_valid;
    logic                            decoded_reg_write_enable;
    logic                            decoded_mem_write_enable;
    logic                            decoded_mem_read_enable;
    logic                            decoded_branch;
    logic                            decoded_scalar_instruction;
    logic                            decoded_halt;
    logic                            decoded_illegal;
    warp_decode_pkg::reg_input_mux_t decoded_reg_input_mux;
    warp_decode_pkg::data_t          decoded_immediate;
    warp_decode_pkg::reg_addr_t      decoded_rd_address;
    warp_decode_pkg::reg_addr_t      decoded_rs1_address;
    warp_decode_pkg::reg_addr_t      decoded_rs2_address;
    warp_decode_pkg::alu_op_t        decoded_alu_instruction;

    warp_decode_pkg::instruction_t instr_tab[$];
    int                            gap_tab[$];
    integer                        seed;
    int                            total_gaps;
    int                            limit_cycles;
    logic                          table_ready;

    warp_decoder UUT (.*);

    decode_checker u_check (.*);

    always #2 clk = ~clk;

    // opcode, bits 28:19, rs2, funct4, rs1, rd
    function automatic logic [31:0] encode(input logic [2:0] op, input logic [9:0] hi,
                                           input logic [4:0] rs2, input logic [3:0] f4,
                                           input logic [4:0] rs1, input logic [4:0] rd);
        return {op, hi, rs2, f4, rs1, rd};
    endfunction

    function automatic logic [31:0] sext(input logic [31:0] value, input int width);
        logic [31:0] v;
        v = value << (32 - width);
        return $signed(v) >>> (32 - width);
    endfunction

    // Expected bundle in the checker's field layout
    function automatic logic [60:0] expect_bundle(input logic [31:0] ins);
        logic we, mw, mr, br, sc, ht, ill;
        logic [1:0]  mux;
        logic [31:0] imm;
        logic [4:0]  rd, rs1, rs2, alu;
        logic [2:0]  op, f3;
        logic [3:0]  f4;
        op = ins[31:29];
        f3 = ins[12:10];
        f4 = ins[13:10];
        {we, mw, mr, br, sc, ht, ill} = '0;
        mux = warp_decode_pkg::ALU_OUT;
        imm = '0;
        {rd, rs1, rs2} = '0;
        alu = warp_decode_pkg::ALU_NOP;
        if (op == 3'b000 || op == 3'b001 || op == 3'b101) begin
            we = 1'b1;
            rd = ins[4:0];
            rs1 = ins[9:5];
            if (op != 3'b001) rs2 = ins[18:14];
            if (op != 3'b101) sc = ins[28];
            ill = 1'b1;
            if (op == 3'b000 && f4 <= 9) begin
                ill = 1'b0;
                case (f4)
                    0: alu = warp_decode_pkg::ADD;
                    1: alu = warp_decode_pkg::SUB;
                    2: alu = warp_decode_pkg::MUL;
                    3: alu = warp_decode_pkg::DIV;
                    4: alu = warp_decode_pkg::SLT;
                    5: alu = warp_decode_pkg::SLL;
                    6: alu = warp_decode_pkg::SEQ;
                    7: alu = warp_decode_pkg::SNEZ;
                    8: alu = warp_decode_pkg::MIN;
                    default: alu = warp_decode_pkg::ABS;
                endcase
            end
            if (op == 3'b001) begin
                imm = sext(ins[27:14], 14);
                ill = 1'b0;
                if (f4 == 0) alu = warp_decode_pkg::ADDI;
                else if (f4 == 2) alu = warp_decode_pkg::MULI;
                else if (f4 == 3) alu = warp_decode_pkg::DIVI;
                else if (f4 == 10) alu = warp_decode_pkg::SLLI;
                else if (f4 == 11) alu = warp_decode_pkg::SEQI;
                else ill = 1'b1;
            end
            if (op == 3'b101) begin
                mux = warp_decode_pkg::VECTOR_TO_SCALAR;
                ill = (f4 != 0);
                if (f4 == 0) alu = warp_decode_pkg::SLT;
            end
        end else if (op == 3'b011 && f3 == 3'b000) begin
            {we, mr, rd, rs1, sc} = {2'b11, ins[4:0], ins[9:5], ins[13]};
            mux = warp_decode_pkg::LSU_OUT;
            imm = sext(ins[28:14], 15);
            alu = warp_decode_pkg::ADDI;
        end else if (op == 3'b011 && f3 == 3'b001) begin
            {mw, rs1, rs2, sc} = {1'b1, ins[9:5], ins[18:14], ins[13]};
            imm = sext({ins[28:19], ins[4:0]}, 15);
            alu = warp_decode_pkg::ADDI;
        end else if (op == 3'b100) begin
            {we, rd, sc} = {1'b1, ins[4:0], ins[5]};
            mux = warp_decode_pkg::IMMEDIATE;
            imm = {ins[28:9], 12'b0};
        end else if (op == 3'b111 && (f3 == 3'b001 || f3 == 3'b010)) begin
            {br, sc, rs1, rs2} = {2'b11, ins[9:5], ins[18:14]};
            imm = sext({ins[28:19], ins[13], ins[4:0]}, 16);
            alu = (f3 == 3'b001) ? warp_decode_pkg::BEQZ : warp_decode_pkg::BEQO;
        end else if (op == 3'b111 && f3 == 3'b000) begin
            sc = 1'b1;
            imm = sext({ins[28:13], ins[9:0]}, 26);
            alu = warp_decode_pkg::JAL;
        end else if (op == 3'b111 && f3 == 3'b111) begin
            {ht, sc} = 2'b11;
        end else begin
            ill = 1'b1;
        end
        return {we, mw, mr, br, sc, ht, ill, mux, imm, rd, rs1, rs2, alu};
    endfunction

    task automatic build_table();
        logic [31:0] r;
        for (int f = 0; f < 16; f++) begin
            instr_tab.push_back(encode(3'b000, {f[0], 9'h0a5}, 5'(3 + f), 4'(f), 5'd7,
                                       5'(31 - f)));
            instr_tab.push_back(encode(3'b001, {f[1], 9'h1f3}, 5'd9, 4'(f), 5'd12, 5'(f)));
        end
        instr_tab.push_back(encode(3'b011, 10'h00c, 5'd4, 4'b0000, 5'd2, 5'd6));
        instr_tab.push_back(encode(3'b011, 10'h3ff, 5'd30, 4'b1000, 5'd2, 5'd6));
        instr_tab.push_back(encode(3'b011, 10'h3f0, 5'd17, 4'b1001, 5'd8, 5'd21));
        instr_tab.push_back(encode(3'b011, 10'h010, 5'd17, 4'b0001, 5'd8, 5'd3));
        instr_tab.push_back(encode(3'b011, 10'h010, 5'd17, 4'b0010, 5'd8, 5'd3));
        instr_tab.push_back(encode(3'b111, 10'h3fe, 5'd5, 4'b1001, 5'd4, 5'd16));
        instr_tab.push_back(encode(3'b111, 10'h004, 5'd5, 4'b0010, 5'd4, 5'd1));
        instr_tab.push_back(encode(3'b111, 10'h200, 5'd0, 4'b1000, 5'd9, 5'd2));
        instr_tab.push_back(encode(3'b111, 10'h001, 5'd1, 4'b0000, 5'd9, 5'd2));
        instr_tab.push_back(encode(3'b111, 10'h000, 5'd0, 4'b0111, 5'd0, 5'd0));
        instr_tab.push_back(encode(3'b111, 10'h155, 5'd3, 4'b0011, 5'd3, 5'd3));
        instr_tab.push_back(encode(3'b100, 10'h2ab, 5'd19, 4'b1010, 5'd21, 5'd11));
        instr_tab.push_back(encode(3'b100, 10'h001, 5'd0, 4'b0000, 5'd0, 5'd4));
        instr_tab.push_back(encode(3'b101, 10'h200, 5'd6, 4'b0000, 5'd7, 5'd8));
        instr_tab.push_back(encode(3'b101, 10'h000, 5'd6, 4'b0001, 5'd7, 5'd8));
        instr_tab.push_back(encode(3'b010, 10'h3ff, 5'd6, 4'b0000, 5'd7, 5'd8));
        // Random R and I instructions
        for (int i = 0; i < 16; i++) begin
            r = $random(seed);
            instr_tab.push_back({2'b00, r[31], r[28:0]});
        end
        total_gaps = 0;
        foreach (instr_tab[i]) begin
            gap_tab.push_back((i % 5 == 0) ? 2 : ((i % 7 == 3) ? 1 : 0));
            total_gaps += gap_tab[i];
        end
    endtask

    initial begin
        seed = 32'h87e5;
        table_ready = 1'b0;
        clk = 1'b0;
        reset = 1'b1;
        decode_valid = 1'b0;
        instruction = '0;
        build_table();
        table_ready = 1'b1;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        // Idle cycles so the reset values are observed before the first strobe
        repeat (3) @(posedge clk);
        foreach (instr_tab[i]) begin
            repeat (gap_tab[i]) begin
                @(posedge clk);
                decode_valid <= 1'b0;
                instruction <= '0;
            end
            @(posedge clk);
            decode_valid <= 1'b1;
            instruction <= instr_tab[i];
            u_check.push_expected(expect_bundle(instr_tab[i]));
        end
        @(posedge clk);
        decode_valid <= 1'b0;
        instruction <= '0;
        repeat (3) @(posedge clk);
        u_check.final_report();
        if (u_check.error_count() == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        wait (table_ready);
        limit_cycles = instr_tab.size() + total_gaps + 20;
        #(limit_cycles * 4);
        $display("Timeout: run did not finish within %0d cycles", limit_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* filelist.f */
hdl/warp_decode_pkg.sv
hdl/format_decode.sv
hdl/alu_op_decode.sv
hdl/imm_gen.sv
hdl/warp_decoder.sv
verification/decode_checker.sv
verification/warp_decoder_tb.sv
